// File: hw/ieu_pkg.sv
/*
 * Shared definitions of the integer execution unit.
 * PC values and branch targets are word addresses, so DW must equal PCW + 2.
 * Op and size encodings are fixed; the testbench relies on them.
 */
`default_nettype none

package ieu_pkg;

   localparam int DW  = 32;  // Data width
   localparam int PCW = 30;  // Word-address width

   typedef logic [DW-1:0]  word_t;
   typedef logic [PCW-1:0] pc_t;

   typedef enum logic [3:0] {
      OP_ADD     = 4'd0,
      OP_SUB     = 4'd1,
      OP_AND     = 4'd2,
      OP_OR      = 4'd3,
      OP_XOR     = 4'd4,
      OP_SHL     = 4'd5,
      OP_SHR     = 4'd6,
      OP_SRA     = 4'd7,
      OP_CMP_EQ  = 4'd8,   // Compares only update cc
      OP_CMP_LT  = 4'd9,
      OP_CMP_LTU = 4'd10,
      OP_LOAD    = 4'd11,
      OP_STORE   = 4'd12,
      OP_JMPREL  = 4'd13,  // Conditional on cc
      OP_JMPFAR  = 4'd14   // Register indirect
   } ieu_op_e;

   typedef enum logic [1:0] {
      SIZE_B = 2'd0,
      SIZE_H = 2'd1,
      SIZE_W = 2'd2
   } mem_size_e;

endpackage

`default_nettype wire

// File: hw/ieu_issue.sv
/*
 * Issue register. Holds one operation until it retires.
 * Non-memory ops retire one cycle after capture, memory ops on the bus ack.
 * in_ready_o stays low in the first cycle after reset.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_issue import ieu_pkg::*; #(
   parameter int REG_AW = 5
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              in_valid_i,
   input  ieu_op_e           op_i,
   input  word_t             operand_1_i,
   input  word_t             operand_2_i,
   input  word_t             operand_3_i,
   input  mem_size_e         size_i,
   input  logic              sign_ext_i,
   input  logic              wb_en_i,
   input  logic [REG_AW-1:0] wb_addr_i,
   input  pc_t               pc_i,
   input  logic              pred_taken_i,
   input  pc_t               pred_tgt_i,
   input  logic              lsu_ack_i,
   output logic              in_ready_o,
   output logic              iss_valid_o,
   output ieu_op_e           iss_op_o,
   output word_t             iss_a_o,
   output word_t             iss_b_o,
   output word_t             iss_c_o,
   output mem_size_e         iss_size_o,
   output logic              iss_sext_o,
   output logic              iss_wb_en_o,
   output logic [REG_AW-1:0] iss_wb_addr_o,
   output pc_t               iss_pc_o,
   output logic              iss_pred_taken_o,
   output pc_t               iss_pred_tgt_o,
   output logic              iss_retire_o
);
   logic run_q;   // Set one cycle after reset
   logic is_mem;
   logic accept;

   assign is_mem       = (iss_op_o == OP_LOAD) || (iss_op_o == OP_STORE);
   assign iss_retire_o = iss_valid_o & (is_mem ? lsu_ack_i : 1'b1);
   assign in_ready_o   = run_q & (~iss_valid_o | iss_retire_o);
   assign accept       = in_valid_i & in_ready_o;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         run_q       <= 1'b0;
         iss_valid_o <= 1'b0;
      end else begin
         run_q <= 1'b1;
         if (accept)
            iss_valid_o <= 1'b1;
         else if (iss_retire_o)
            iss_valid_o <= 1'b0;
      end
   end

   // Payload, only meaningful while iss_valid_o is set
   always_ff @(posedge clk) begin
      if (accept) begin
         iss_op_o         <= op_i;
         iss_a_o          <= operand_1_i;
         iss_b_o          <= operand_2_i;
         iss_c_o          <= operand_3_i;
         iss_size_o       <= size_i;
         iss_sext_o       <= sign_ext_i;
         iss_wb_en_o      <= wb_en_i;
         iss_wb_addr_o    <= wb_addr_i;
         iss_pc_o         <= pc_i;
         iss_pred_taken_o <= pred_taken_i;
         iss_pred_tgt_o   <= pred_tgt_i;
      end
   end

endmodule

`default_nettype wire

// File: hw/ieu_alu.sv
/*
 * Arithmetic, logic and shift unit with the condition flag register.
 * Shift amounts use only the low 5 bits of operand 2.
 * cc changes only when a compare retires.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_alu import ieu_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  logic    iss_valid_i,
   input  logic    iss_retire_i,
   input  ieu_op_e iss_op_i,
   input  word_t   iss_a_i,
   input  word_t   iss_b_i,
   output word_t   alu_result_o,
   output logic    cc_o
);
   logic [4:0] shamt;
   word_t      result;
   logic       cmp_op;
   logic       cmp_res;

   assign shamt = iss_b_i[4:0];

   always_comb begin
      result  = '0;
      cmp_op  = 1'b0;
      cmp_res = 1'b0;
      case (iss_op_i)
         OP_ADD:  result = iss_a_i + iss_b_i;
         OP_SUB:  result = iss_a_i - iss_b_i;
         OP_AND:  result = iss_a_i & iss_b_i;
         OP_OR:   result = iss_a_i | iss_b_i;
         OP_XOR:  result = iss_a_i ^ iss_b_i;
         OP_SHL:  result = iss_a_i << shamt;
         OP_SHR:  result = iss_a_i >> shamt;
         OP_SRA:  result = word_t'($signed(iss_a_i) >>> shamt);
         OP_CMP_EQ: begin
            cmp_op  = 1'b1;
            cmp_res = (iss_a_i == iss_b_i);
         end
         OP_CMP_LT: begin
            cmp_op  = 1'b1;
            cmp_res = ($signed(iss_a_i) < $signed(iss_b_i));
         end
         OP_CMP_LTU: begin
            cmp_op  = 1'b1;
            cmp_res = (iss_a_i < iss_b_i);
         end
         default: result = '0;  // Memory and jumps take no ALU result
      endcase
   end

   assign alu_result_o = iss_valid_i ? result : '0;  // Quiet while idle

   always_ff @(posedge clk) begin
      if (rst_i)
         cc_o <= 1'b0;
      else if (iss_valid_i && iss_retire_i && cmp_op)
         cc_o <= cmp_res;
   end

endmodule

`default_nettype wire

// File: hw/ieu_branch_check.sv
/*
 * Branch and jump check against the fetch-side prediction.
 * A mismatch gives a one-cycle flush pulse with the correct word target.
 * Younger operations are not squashed here.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_branch_check import ieu_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  logic    iss_retire_i,
   input  ieu_op_e iss_op_i,
   input  word_t   iss_a_i,
   input  pc_t     iss_pc_i,
   input  logic    iss_pred_taken_i,
   input  pc_t     iss_pred_tgt_i,
   input  logic    cc_i,
   output logic    flush_o,
   output pc_t     flush_tgt_o
);
   pc_t  pc_next;
   pc_t  far_tgt;
   logic rel_miss;
   logic far_miss;

   assign pc_next  = iss_pc_i + pc_t'(1);
   assign far_tgt  = iss_a_i[DW-1:2];  // Byte to word address
   assign rel_miss = (iss_op_i == OP_JMPREL) && (iss_pred_taken_i != cc_i);
   assign far_miss = (iss_op_i == OP_JMPFAR) && (iss_pred_tgt_i != far_tgt);

   always_ff @(posedge clk) begin
      if (rst_i)
         flush_o <= 1'b0;
      else
         flush_o <= iss_retire_i & (rel_miss | far_miss);
   end

   always_ff @(posedge clk) begin
      if (iss_retire_i)
         flush_tgt_o <= (iss_op_i == OP_JMPFAR) ? far_tgt : (cc_i ? iss_pred_tgt_i : pc_next);
   end

endmodule

`default_nettype wire

// File: hw/ieu_lsu.sv
/*
 * Wishbone classic master for loads and stores, little-endian lanes.
 * Address bits below the access size are ignored; no misalignment check.
 * Bus signals are combinational from the issue register and stay stable
 * until the ack.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_lsu import ieu_pkg::*; (
   input  logic      iss_valid_i,
   input  ieu_op_e   iss_op_i,
   input  word_t     iss_a_i,
   input  word_t     iss_b_i,
   input  word_t     iss_c_i,
   input  mem_size_e iss_size_i,
   input  logic      iss_sext_i,
   input  word_t     wb_dat_i,
   input  logic      wb_ack_i,
   output logic      wb_cyc_o,
   output logic      wb_stb_o,
   output logic      wb_we_o,
   output word_t     wb_adr_o,
   output logic [3:0] wb_sel_o,
   output word_t     wb_dat_o,
   output logic      lsu_ack_o,
   output word_t     lsu_load_data_o
);
   word_t      addr;
   logic [1:0] lane;     // Byte offset after size masking
   logic       mem_op;
   word_t      shifted;

   assign addr   = iss_a_i + iss_b_i;
   assign mem_op = (iss_op_i == OP_LOAD) || (iss_op_i == OP_STORE);

   assign wb_cyc_o  = iss_valid_i & mem_op;
   assign wb_stb_o  = wb_cyc_o;
   assign wb_we_o   = (iss_op_i == OP_STORE);
   assign wb_adr_o  = {addr[DW-1:2], 2'b00};
   assign lsu_ack_o = wb_cyc_o & wb_ack_i;

   always_comb begin
      case (iss_size_i)
         SIZE_B:  lane = addr[1:0];
         SIZE_H:  lane = {addr[1], 1'b0};
         default: lane = 2'b00;
      endcase
   end

   // Byte selects and store lane replication
   always_comb begin
      case (iss_size_i)
         SIZE_B: begin
            wb_sel_o = 4'b0001 << lane;
            wb_dat_o = {4{iss_c_i[7:0]}};
         end
         SIZE_H: begin
            wb_sel_o = lane[1] ? 4'b1100 : 4'b0011;
            wb_dat_o = {2{iss_c_i[15:0]}};
         end
         default: begin
            wb_sel_o = 4'b1111;
            wb_dat_o = iss_c_i;
         end
      endcase
   end

   assign shifted = wb_dat_i >> {lane, 3'b000};

   // Load extension
   always_comb begin
      case (iss_size_i)
         SIZE_B: begin
            if (iss_sext_i)
               lsu_load_data_o = {{24{shifted[7]}}, shifted[7:0]};
            else
               lsu_load_data_o = {24'h0, shifted[7:0]};
         end
         SIZE_H: begin
            if (iss_sext_i)
               lsu_load_data_o = {{16{shifted[15]}}, shifted[15:0]};
            else
               lsu_load_data_o = {16'h0, shifted[15:0]};
         end
         default: lsu_load_data_o = shifted;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/ieu_writeback.sv
/*
 * Register-file write port, registered at the retire edge.
 * The write is visible for exactly one cycle.
 * Stores and compares never write, even with wb_en set.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_writeback import ieu_pkg::*; #(
   parameter int REG_AW = 5
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              iss_retire_i,
   input  ieu_op_e           iss_op_i,
   input  logic              iss_wb_en_i,
   input  logic [REG_AW-1:0] iss_wb_addr_i,
   input  pc_t               iss_pc_i,
   input  word_t             alu_result_i,
   input  word_t             lsu_load_data_i,
   output logic              regf_we_o,
   output logic [REG_AW-1:0] regf_addr_o,
   output word_t             regf_data_o
);
   pc_t   pc_next;
   word_t link_addr;
   word_t wb_data;
   logic  no_write;

   assign pc_next   = iss_pc_i + pc_t'(1);
   assign link_addr = {pc_next, 2'b00};  // Byte address of next insn

   assign no_write = (iss_op_i == OP_STORE) || (iss_op_i == OP_CMP_EQ)
                     || (iss_op_i == OP_CMP_LT) || (iss_op_i == OP_CMP_LTU);

   always_comb begin
      case (iss_op_i)
         OP_LOAD:              wb_data = lsu_load_data_i;
         OP_JMPREL, OP_JMPFAR: wb_data = link_addr;
         default:              wb_data = alu_result_i;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i)
         regf_we_o <= 1'b0;
      else
         regf_we_o <= iss_retire_i & iss_wb_en_i & ~no_write;
   end

   always_ff @(posedge clk) begin
      if (iss_retire_i) begin
         regf_addr_o <= iss_wb_addr_i;
         regf_data_o <= wb_data;
      end
   end

endmodule

`default_nettype wire

// File: hw/ieu_top.sv
/*
 * Integer execution unit top level, one operation in flight at a time.
 * Results, cc and flush appear one cycle after the operation retires.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_top import ieu_pkg::*; #(
   parameter int REG_AW = 5
) (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              in_valid_i,
   input  ieu_op_e           op_i,
   input  word_t             operand_1_i,
   input  word_t             operand_2_i,
   input  word_t             operand_3_i,
   input  mem_size_e         size_i,
   input  logic              sign_ext_i,
   input  logic              wb_en_i,
   input  logic [REG_AW-1:0] wb_addr_i,
   input  pc_t               pc_i,
   input  logic              pred_taken_i,
   input  pc_t               pred_tgt_i,
   input  word_t             wb_dat_i,
   input  logic              wb_ack_i,
   output logic              in_ready_o,
   output logic              regf_we_o,
   output logic [REG_AW-1:0] regf_addr_o,
   output word_t             regf_data_o,
   output logic              cc_o,
   output logic              flush_o,
   output pc_t               flush_tgt_o,
   output logic              wb_cyc_o,
   output logic              wb_stb_o,
   output logic              wb_we_o,
   output word_t             wb_adr_o,
   output logic [3:0]        wb_sel_o,
   output word_t             wb_dat_o
);
   logic              iss_valid;
   ieu_op_e           iss_op;
   word_t             iss_a;
   word_t             iss_b;
   word_t             iss_c;
   mem_size_e         iss_size;
   logic              iss_sext;
   logic              iss_wb_en;
   logic [REG_AW-1:0] iss_wb_addr;
   pc_t               iss_pc;
   logic              iss_pred_taken;
   pc_t               iss_pred_tgt;
   logic              iss_retire;
   logic              lsu_ack;
   word_t             lsu_load_data;
   word_t             alu_result;
   logic              cc;

   assign cc_o = cc;

   ieu_issue #(.REG_AW(REG_AW)) issue_i (
      .clk, .rst_i, .in_valid_i, .op_i, .operand_1_i, .operand_2_i, .operand_3_i,
      .size_i, .sign_ext_i, .wb_en_i, .wb_addr_i, .pc_i, .pred_taken_i, .pred_tgt_i,
      .lsu_ack_i        (lsu_ack),
      .in_ready_o,
      .iss_valid_o      (iss_valid),
      .iss_op_o         (iss_op),
      .iss_a_o          (iss_a),
      .iss_b_o          (iss_b),
      .iss_c_o          (iss_c),
      .iss_size_o       (iss_size),
      .iss_sext_o       (iss_sext),
      .iss_wb_en_o      (iss_wb_en),
      .iss_wb_addr_o    (iss_wb_addr),
      .iss_pc_o         (iss_pc),
      .iss_pred_taken_o (iss_pred_taken),
      .iss_pred_tgt_o   (iss_pred_tgt),
      .iss_retire_o     (iss_retire)
   );

   ieu_alu alu_i (
      .clk, .rst_i,
      .iss_valid_i  (iss_valid),
      .iss_retire_i (iss_retire),
      .iss_op_i     (iss_op),
      .iss_a_i      (iss_a),
      .iss_b_i      (iss_b),
      .alu_result_o (alu_result),
      .cc_o         (cc)
   );

   ieu_branch_check branch_check_i (
      .clk, .rst_i,
      .iss_retire_i     (iss_retire),
      .iss_op_i         (iss_op),
      .iss_a_i          (iss_a),
      .iss_pc_i         (iss_pc),
      .iss_pred_taken_i (iss_pred_taken),
      .iss_pred_tgt_i   (iss_pred_tgt),
      .cc_i             (cc),
      .flush_o, .flush_tgt_o
   );

   ieu_lsu lsu_i (
      .iss_valid_i (iss_valid),
      .iss_op_i    (iss_op),
      .iss_a_i     (iss_a),
      .iss_b_i     (iss_b),
      .iss_c_i     (iss_c),
      .iss_size_i  (iss_size),
      .iss_sext_i  (iss_sext),
      .wb_dat_i, .wb_ack_i,
      .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_sel_o, .wb_dat_o,
      .lsu_ack_o       (lsu_ack),
      .lsu_load_data_o (lsu_load_data)
   );

   ieu_writeback #(.REG_AW(REG_AW)) writeback_i (
      .clk, .rst_i,
      .iss_retire_i    (iss_retire),
      .iss_op_i        (iss_op),
      .iss_wb_en_i     (iss_wb_en),
      .iss_wb_addr_i   (iss_wb_addr),
      .iss_pc_i        (iss_pc),
      .alu_result_i    (alu_result),
      .lsu_load_data_i (lsu_load_data),
      .regf_we_o, .regf_addr_o, .regf_data_o
   );

endmodule

`default_nettype wire

// File: dv/ieu_wb_mem.sv
/*
 * Wishbone classic slave memory, 64 words, for the IEU testbench.
 * Only address bits 7:2 are decoded. Ack comes from a register after
 * 0 to 3 random wait cycles, so it is stable between clock edges.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_wb_mem #(
   parameter int unsigned SEED = 32'h3e62
) (
   input  logic        clk,
   input  logic        rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [3:0]  sel_i,
   input  logic [31:0] dat_i,
   output logic [31:0] dat_o,
   output logic        ack_o
);
   logic [31:0] mem [64];
   logic [5:0]  idx;
   logic [1:0]  wait_cnt;  // Cycles left before the next ack

   assign idx = adr_i[7:2];

   initial begin
      void'($urandom(SEED));
      for (int i = 0; i < 64; i++)
         mem[i] = (i + 1) * 32'h9e37_79b9;  // Fill depends on the whole address
      ack_o    <= 1'b0;
      dat_o    <= '0;
      wait_cnt <= 2'($urandom % 4);
      forever begin
         @(posedge clk);
         if (rst_i) begin
            ack_o <= 1'b0;
         end else if (cyc_i && stb_i && !ack_o) begin
            if (wait_cnt == 2'd0) begin
               ack_o <= 1'b1;
               dat_o <= mem[idx];
               if (we_i) begin
                  for (int b = 0; b < 4; b++)
                     if (sel_i[b])
                        mem[idx][8*b +: 8] = dat_i[8*b +: 8];
               end
               wait_cnt <= 2'($urandom % 4);
            end else begin
               wait_cnt <= wait_cnt - 2'd1;
            end
         end else begin
            ack_o <= 1'b0;  // One-cycle ack
         end
      end
   end

endmodule

`default_nettype wire

// File: dv/ieu_tb.sv
/*
 * Table-driven, pipelined testbench of the integer execution unit.
 * Inputs change on the falling edge, outputs are checked there too.
 * Loads only read words that earlier rows of the table stored.
 */
`timescale 1ns/1ps
`default_nettype none

module ieu_tb import ieu_pkg::*; ();
   localparam int REG_AW = 5;

   typedef struct packed {
      ieu_op_e           op;
      word_t             a;
      word_t             b;
      word_t             c;
      mem_size_e         size;
      logic              sext;
      logic              wb_en;
      logic [REG_AW-1:0] wb_addr;
      pc_t               pc;
      logic              pred_taken;
      pc_t               pred_tgt;
      logic              exp_we;
      word_t             exp_data;
      logic              exp_cc;
      logic              exp_flush;
      pc_t               exp_tgt;
   } row_t;

   logic clk, rst_i, in_valid_i, sign_ext_i, wb_en_i, pred_taken_i, wb_ack_i;
   ieu_op_e           op_i;
   word_t             operand_1_i, operand_2_i, operand_3_i, wb_dat_i;
   mem_size_e         size_i;
   logic [REG_AW-1:0] wb_addr_i, regf_addr_o;
   pc_t               pc_i, pred_tgt_i, flush_tgt_o;
   logic              in_ready_o, regf_we_o, cc_o, flush_o;
   logic              wb_cyc_o, wb_stb_o, wb_we_o;
   word_t             regf_data_o, wb_adr_o, wb_dat_o;
   logic [3:0]        wb_sel_o;

   row_t  tab[$];
   string tab_name[$];
   int    error_cnt, pass_cnt, fail_cnt, cycle_cnt, cycle_limit;
   int    next_row, held_row, chk_row;
   logic  retire_now, all_done, bus_exp;
   string bus_name;

   ieu_top #(.REG_AW(REG_AW)) ieu_top_i (.*);

   ieu_wb_mem #(.SEED(32'h3e62)) wb_mem_i (
      .clk, .rst_i,
      .cyc_i (wb_cyc_o), .stb_i (wb_stb_o), .we_i (wb_we_o), .adr_i (wb_adr_o),
      .sel_i (wb_sel_o), .dat_i (wb_dat_o), .dat_o (wb_dat_i), .ack_o (wb_ack_i)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic is_mem(input ieu_op_e op);
      return (op == OP_LOAD) || (op == OP_STORE);
   endfunction

   task automatic add_row(input string name, input row_t r);
      tab_name.push_back(name);
      tab.push_back(r);
   endtask

   task automatic drive_row(input row_t r);
      op_i         = r.op;
      operand_1_i  = r.a;
      operand_2_i  = r.b;
      operand_3_i  = r.c;
      size_i       = r.size;
      sign_ext_i   = r.sext;
      wb_en_i      = r.wb_en;
      wb_addr_i    = r.wb_addr;
      pc_i         = r.pc;
      pred_taken_i = r.pred_taken;
      pred_tgt_i   = r.pred_tgt;
   endtask

   task automatic check_field(input string test, input string field,
                              input word_t exp, input word_t act);
      assert (act === exp) else begin
         $display("** Error %s: %s expected %h, actual %h", test, field, exp, act);
         error_cnt++;
      end
   endtask

   // Outputs of a row in the cycle after its retire edge
   task automatic check_row(input int idx);
      row_t r;
      int   errs_before;
      r = tab[idx];
      errs_before = error_cnt;
      check_field(tab_name[idx], "regf_we_o", 32'(r.exp_we), 32'(regf_we_o));
      if (r.exp_we) begin
         check_field(tab_name[idx], "regf_addr_o", 32'(r.wb_addr), 32'(regf_addr_o));
         check_field(tab_name[idx], "regf_data_o", r.exp_data, regf_data_o);
      end
      check_field(tab_name[idx], "cc_o", 32'(r.exp_cc), 32'(cc_o));
      check_field(tab_name[idx], "flush_o", 32'(r.exp_flush), 32'(flush_o));
      if (r.exp_flush)
         check_field(tab_name[idx], "flush_tgt_o", 32'(r.exp_tgt), 32'(flush_tgt_o));
      if (error_cnt == errs_before) begin
         pass_cnt++;
         $display("PASS %s", tab_name[idx]);
      end else begin
         fail_cnt++;
         $display("FAIL %s", tab_name[idx]);
      end
   endtask

   task automatic build_table();
      // op a b c size sext wb_en rd / pc pred_taken pred_tgt we data cc flush tgt
      add_row("add", '{OP_ADD, 32'h5, 32'h7, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd3,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hc, 1'b0, 1'b0, 30'h0});
      add_row("sub_neg", '{OP_SUB, 32'h5, 32'h7, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd4,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hffff_fffe, 1'b0, 1'b0, 30'h0});
      add_row("and", '{OP_AND, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd5,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h00f0_00f0, 1'b0, 1'b0, 30'h0});
      add_row("or", '{OP_OR, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd6,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hfff0_fff0, 1'b0, 1'b0, 30'h0});
      add_row("xor", '{OP_XOR, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd7,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hff00_ff00, 1'b0, 1'b0, 30'h0});
      add_row("shl_mod32", '{OP_SHL, 32'h1234, 32'd36, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd8,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h1_2340, 1'b0, 1'b0, 30'h0});
      add_row("shr", '{OP_SHR, 32'h8000_0000, 32'd31, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd9,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h1, 1'b0, 1'b0, 30'h0});
      add_row("sra_neg", '{OP_SRA, 32'h8000_0010, 32'd4, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd10,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hf800_0001, 1'b0, 1'b0, 30'h0});
      // Compares never write, even with wb_en
      add_row("cmp_eq_t", '{OP_CMP_EQ, 32'h7, 32'h7, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd11,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b1, 1'b0, 30'h0});
      add_row("cmp_ltu_f", '{OP_CMP_LTU, 32'hffff_ffff, 32'h1, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd11,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("cmp_lt_t", '{OP_CMP_LT, 32'hffff_ffff, 32'h1, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b1, 1'b0, 30'h0});
      add_row("cmp_lt_f", '{OP_CMP_LT, 32'h1, 32'hffff_ffff, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("cmp_ltu_t", '{OP_CMP_LTU, 32'h1, 32'hffff_ffff, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b1, 1'b0, 30'h0});
      add_row("rel_hit", '{OP_JMPREL, 32'h0, 32'h0, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h100, 1'b1, 30'h200, 1'b0, 32'h0, 1'b1, 1'b0, 30'h0});
      add_row("rel_miss_link", '{OP_JMPREL, 32'h0, 32'h0, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd1,
                       30'h100, 1'b0, 30'h200, 1'b1, 32'h404, 1'b1, 1'b1, 30'h200});
      add_row("cmp_eq_f", '{OP_CMP_EQ, 32'h1, 32'h2, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("rel_miss_nt", '{OP_JMPREL, 32'h0, 32'h0, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h300, 1'b1, 30'h380, 1'b0, 32'h0, 1'b0, 1'b1, 30'h301});
      add_row("rel_hit_nt", '{OP_JMPREL, 32'h0, 32'h0, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h300, 1'b0, 30'h380, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("far_hit_link", '{OP_JMPFAR, 32'h1000, 32'h0, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd31,
                       30'h50, 1'b1, 30'h400, 1'b1, 32'h144, 1'b0, 1'b0, 30'h0});
      add_row("far_miss", '{OP_JMPFAR, 32'h2003, 32'h0, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h50, 1'b1, 30'h400, 1'b0, 32'h0, 1'b0, 1'b1, 30'h800});
      // Stores into words 0x40 and 0x44, then loads at each offset
      add_row("sw_40", '{OP_STORE, 32'h40, 32'h0, 32'h8765_4321, SIZE_W, 1'b0, 1'b1, 5'd2,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("sw_44", '{OP_STORE, 32'h40, 32'h4, 32'h0, SIZE_W, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("sb_45", '{OP_STORE, 32'h40, 32'h5, 32'h1234_56a5, SIZE_B, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("sh_46", '{OP_STORE, 32'h40, 32'h6, 32'habcd_80f1, SIZE_H, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("sb_44", '{OP_STORE, 32'h40, 32'h4, 32'h7f, SIZE_B, 1'b0, 1'b0, 5'd0,
                       30'h0, 1'b0, 30'h0, 1'b0, 32'h0, 1'b0, 1'b0, 30'h0});
      add_row("lw_40", '{OP_LOAD, 32'h40, 32'h0, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd12,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h8765_4321, 1'b0, 1'b0, 30'h0});
      add_row("lbu_41", '{OP_LOAD, 32'h40, 32'h1, 32'h0, SIZE_B, 1'b0, 1'b1, 5'd13,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h43, 1'b0, 1'b0, 30'h0});
      add_row("lb_43", '{OP_LOAD, 32'h40, 32'h3, 32'h0, SIZE_B, 1'b1, 1'b1, 5'd14,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hffff_ff87, 1'b0, 1'b0, 30'h0});
      add_row("lh_42", '{OP_LOAD, 32'h40, 32'h2, 32'h0, SIZE_H, 1'b1, 1'b1, 5'd15,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hffff_8765, 1'b0, 1'b0, 30'h0});
      add_row("lb_45", '{OP_LOAD, 32'h40, 32'h5, 32'h0, SIZE_B, 1'b1, 1'b1, 5'd16,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'hffff_ffa5, 1'b0, 1'b0, 30'h0});
      add_row("lb_44_pos", '{OP_LOAD, 32'h40, 32'h4, 32'h0, SIZE_B, 1'b1, 1'b1, 5'd17,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h7f, 1'b0, 1'b0, 30'h0});
      add_row("lhu_47_odd", '{OP_LOAD, 32'h40, 32'h7, 32'h0, SIZE_H, 1'b0, 1'b1, 5'd18,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h80f1, 1'b0, 1'b0, 30'h0});
      add_row("lw_44", '{OP_LOAD, 32'h40, 32'h4, 32'h0, SIZE_W, 1'b0, 1'b1, 5'd19,
                       30'h0, 1'b0, 30'h0, 1'b1, 32'h80f1_a57f, 1'b0, 1'b0, 30'h0});
   endtask

   initial begin
      rst_i      = 1'b1;
      in_valid_i = 1'b0;
      drive_row('0);
      error_cnt  = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      cycle_cnt  = 0;
      next_row   = 0;
      held_row   = -1;  // Row in the issue register
      chk_row    = -1;  // Row that retired at the last rising edge
      all_done   = 1'b0;
      build_table();
      cycle_limit = 10 * tab.size();
      repeat (16) @(negedge clk);
      rst_i = 1'b0;

      while (!all_done && cycle_cnt < cycle_limit) begin
         @(negedge clk);
         cycle_cnt++;
         if (chk_row >= 0)
            check_row(chk_row);
         else
            assert (!regf_we_o && !flush_o) else begin
               $display("Register write or flush seen with no operation retiring");
               error_cnt++;
            end
         chk_row = -1;
         // Bus cycle only while a load or store sits in the issue register
         bus_exp  = (held_row >= 0) && is_mem(tab[held_row].op);
         bus_name = (held_row >= 0) ? tab_name[held_row] : "idle";
         check_field(bus_name, "wb_cyc_o", 32'(bus_exp), 32'(wb_cyc_o));
         check_field(bus_name, "wb_stb_o", 32'(bus_exp), 32'(wb_stb_o));
         // Non-memory ops retire at once, memory ops on the ack
         retire_now = (held_row >= 0) && (!is_mem(tab[held_row].op) || wb_ack_i);
         if (held_row >= 0)
            check_field(tab_name[held_row], "in_ready_o", 32'(retire_now), 32'(in_ready_o));
         if (next_row < tab.size()) begin
            drive_row(tab[next_row]);
            in_valid_i = 1'b1;
         end else begin
            in_valid_i = 1'b0;
         end
         if (retire_now) begin
            chk_row  = held_row;
            held_row = -1;
         end
         if (in_valid_i && in_ready_o) begin
            held_row = next_row;
            next_row++;
         end
         all_done = (next_row == tab.size()) && (held_row < 0) && (chk_row < 0);
      end

      if (!all_done)
         $display("Timeout: table not finished after %0d cycles", cycle_cnt);
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               tab.size(), pass_cnt, fail_cnt, error_cnt);
      if (all_done && fail_cnt == 0 && error_cnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
hw/ieu_pkg.sv
hw/ieu_issue.sv
hw/ieu_alu.sv
hw/ieu_branch_check.sv
hw/ieu_lsu.sv
hw/ieu_writeback.sv
hw/ieu_top.sv
dv/ieu_wb_mem.sv
dv/ieu_tb.sv

// File: Makefile
# Verilator build and run of the IEU testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/Vieu_tb

obj_dir/Vieu_tb: sources.f $(wildcard hw/*.sv dv/*.sv)
	verilator --binary --timing --top-module ieu_tb -f sources.f

run: compile
	./obj_dir/Vieu_tb | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
